//--- program.hex
// four 32-bit instruction words per line, the first line starts at word 0
// top nibble is the opcode, a branch keeps its target word in bits 23 to 0
00000000 10000001 00000002 10000003
00000004 10000005 00000006 10000007
00000008 10000009 30000028 2000000b
2000000c 2000000d 2000000e 2000000f
20000010 20000011 20000012 20000013
20000014 20000015 20000016 20000017
20000018 20000019 2000001a 2000001b
2000001c 2000001d 2000001e 2000001f
20000020 20000021 20000022 20000023
20000024 20000025 20000026 20000027
10000028 10000029 1000002a 1000002b
1000002c 7000002d 0000002e 1000002f
20000030 10000031 00000032 20000033
10000034 00000035 20000036 10000037
00000038 20000039 1000003a 0000003b
2000003c 1000003d 0000003e 2000003f

//--- compile.f
fetch_pkg.sv
fetch_imem.sv
fetch_prefetch.sv
fetch_decode.sv
fetch_top.sv
tb_fetch_top.sv

//--- tb_fetch_top.sv
// testbench for the fetch front end with a reference program model and concurrent checks

`timescale 1ns/1ps

module tb_fetch_top;

	import fetch_pkg::*;

	// six behaviors are exercised, each is given 200 cycles of budget
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

	logic                i_clk;
	logic                i_arst_n;
	logic                i_ready;
	logic                i_jump;
	logic [FETCH_AW-1:0] i_jump_pc;
	logic                i_flush;
	logic                o_valid;
	logic [FETCH_AW-1:0] o_pc;
	logic [FETCH_DW-1:0] o_insn;
	fetch_op_e           o_op;
	logic                o_bus_err;
	logic                o_illegal_op;

	// private copy of the instruction image
	logic [FETCH_DW-1:0] image [IMEM_DEPTH];

	// reference model state
	logic [FETCH_AW-1:0] exp_pc;
	logic                after_err;
	int                  err_items;
	logic                saw_branch;
	logic                saw_undef;
	logic                saw_stall;
	logic                saw_flush;
	logic                saw_jump;
	logic                flush_done;

	int seed = 85243;
	int err_value;
	int err_flow;
	int err_hold;
	int err_reach;

	fetch_top u_dut
	(
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_ready      (i_ready),
		.o_valid      (o_valid),
		.o_pc         (o_pc),
		.o_insn       (o_insn),
		.o_op         (o_op),
		.o_bus_err    (o_bus_err),
		.o_illegal_op (o_illegal_op),
		.i_jump       (i_jump),
		.i_jump_pc    (i_jump_pc),
		.i_flush      (i_flush)
	);

	always #4 i_clk = ~i_clk;

	// opcode expected from the top nibble, unknown codes are undefined
	function automatic fetch_op_e op_from_nibble(input logic [3:0] nib);
		fetch_op_e op;
		case (nib)
			4'h0:    op = OP_NOP;
			4'h1:    op = OP_ALU;
			4'h2:    op = OP_LOAD;
			4'h3:    op = OP_BRANCH;
			default: op = OP_UNDEF;
		endcase
		return op;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model, advanced on every consumed output
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		if (!i_arst_n)
		begin
			exp_pc    <= FETCH_RESET_PC;
			after_err <= 1'b0;
		end
		else
		begin
			if (o_valid && !i_ready)
				saw_stall <= 1'b1;
			if (o_valid && i_ready)
			begin
				if (o_bus_err)
				begin
					after_err <= 1'b1;
					err_items <= err_items + 1;
				end
				else if (image[exp_pc[IMEM_AW-1:0]][31:28] == 4'h3)
					// branch target sits in the low 24 bits of the word
					exp_pc <= FETCH_AW'(image[exp_pc[IMEM_AW-1:0]][23:0]);
				else
					exp_pc <= exp_pc + 1'b1;
				if (o_pc == 40)
					saw_branch <= 1'b1;
				if (o_pc == 45 && o_illegal_op)
					saw_undef <= 1'b1;
				if (o_pc == 5 && err_items > 0)
					saw_jump <= 1'b1;
			end
			if (i_flush)
				saw_flush <= 1'b1;
			// the jump replaces whatever the model expected next
			if (i_jump)
			begin
				exp_pc    <= i_jump_pc;
				after_err <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_pc_order: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_valid |-> o_pc == exp_pc)
		else
		begin
			err_value++;
			$display("[ERROR] o_pc: expected %h, got %h", $sampled(exp_pc), $sampled(o_pc));
		end

	a_insn_word: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_valid && !o_bus_err |-> o_insn == image[o_pc[IMEM_AW-1:0]])
		else
		begin
			err_value++;
			$display("[ERROR] o_insn: expected %h, got %h",
				image[$sampled(o_pc[IMEM_AW-1:0])], $sampled(o_insn));
		end

	a_opcode: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_valid && !o_bus_err |-> o_op == op_from_nibble(o_insn[31:28]))
		else
		begin
			err_value++;
			$display("[ERROR] o_op: expected %h, got %h",
				op_from_nibble($sampled(o_insn[31:28])), $sampled(o_op));
		end

	a_illegal_flag: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_valid && !o_bus_err |-> o_illegal_op == (op_from_nibble(o_insn[31:28]) == OP_UNDEF))
		else
		begin
			err_value++;
			$display("[ERROR] o_illegal_op: got %h for o_insn %h",
				$sampled(o_illegal_op), $sampled(o_insn));
		end

	// only addresses past the end of the memory may report a bus error
	a_bus_err: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_valid |-> o_bus_err == (o_pc >= IMEM_DEPTH))
		else
		begin
			err_value++;
			$display("[ERROR] o_bus_err: got %h at o_pc %h", $sampled(o_bus_err), $sampled(o_pc));
		end

	a_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		after_err |-> !o_valid)
		else
		begin
			err_flow++;
			$display("output delivered after a bus error without a jump, pc %h", $sampled(o_pc));
		end

	a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_valid && !i_ready && !i_jump && !i_flush
		|=> o_valid && $stable(o_pc) && $stable(o_insn) && $stable(o_op))
		else
		begin
			err_hold++;
			$display("[ERROR] stalled output changed: o_valid %h, o_pc %h, o_insn %h, o_op %h",
				$sampled(o_valid), $sampled(o_pc), $sampled(o_insn), $sampled(o_op));
		end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	// one cycle of random back-pressure, with a single flush near the start
	task automatic random_cycle();
		@(posedge i_clk);
		i_ready <= ($random(seed) % 4) != 0;
		i_flush <= 1'b0;
		if (!flush_done && o_valid && o_pc == 3)
		begin
			// ready stays high so the word on the output is consumed by the flush
			i_flush    <= 1'b1;
			i_ready    <= 1'b1;
			flush_done = 1'b1;
		end
	endtask

	task automatic issue_jump(input logic [FETCH_AW-1:0] pc);
		@(posedge i_clk);
		i_jump    <= 1'b1;
		i_jump_pc <= pc;
		i_ready   <= 1'b1;
		@(posedge i_clk);
		i_jump    <= 1'b0;
	endtask

	task automatic check_reached();
		if (!saw_branch || !saw_undef || !saw_stall || !saw_flush || !saw_jump)
		begin
			err_reach++;
			$display("not every behavior was reached");
			$display("seen: branch %0d undef %0d stall %0d flush %0d jump %0d",
				saw_branch, saw_undef, saw_stall, saw_flush, saw_jump);
		end
	endtask

	initial
	begin
		$readmemh("program.hex", image);
		i_clk      = 1'b0;
		i_arst_n   = 1'b0;
		i_ready    = 1'b0;
		i_jump     = 1'b0;
		i_jump_pc  = '0;
		i_flush    = 1'b0;
		err_items  = 0;
		saw_branch = 1'b0;
		saw_undef  = 1'b0;
		saw_stall  = 1'b0;
		saw_flush  = 1'b0;
		saw_jump   = 1'b0;
		flush_done = 1'b0;
		repeat (5) @(posedge i_clk);
		i_arst_n <= 1'b1;
		// first run goes through the branch and off the end of memory
		while (err_items < 1)
			random_cycle();
		// the front end has to stay silent until it is redirected
		repeat (20) random_cycle();
		issue_jump(FETCH_AW'(5));
		while (err_items < 2)
			random_cycle();
		repeat (5) random_cycle();
		check_reached();
		$display("summary: value errors %0d, flow errors %0d, hold errors %0d, coverage misses %0d",
			err_value, err_flow, err_hold, err_reach);
		if (err_value + err_flow + err_hold + err_reach == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		$display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- fetch_top.sv
// instruction fetch front end joining decode, prefetch and instruction memory

`timescale 1ns/1ps

module fetch_top
(
	input  logic                          i_clk,
	input  logic                          i_arst_n,
	// consumer side
	input  logic                          i_ready,
	output logic                          o_valid,
	output logic [fetch_pkg::FETCH_AW-1:0] o_pc,
	output logic [fetch_pkg::FETCH_DW-1:0] o_insn,
	output fetch_pkg::fetch_op_e          o_op,
	output logic                          o_bus_err,
	output logic                          o_illegal_op,
	// control side
	input  logic                          i_jump,
	input  logic [fetch_pkg::FETCH_AW-1:0] i_jump_pc,
	input  logic                          i_flush
);

	import fetch_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// decode to prefetch
	////////////////////////////////////////////////////////////////////////////

	logic                fetch_new_pc;
	logic                fetch_clear;
	logic                fetch_ready;
	logic [FETCH_AW-1:0] fetch_pc;
	logic                pf_valid;
	logic                pf_illegal;
	logic [FETCH_DW-1:0] pf_insn;
	logic [FETCH_AW-1:0] pf_pc;

	////////////////////////////////////////////////////////////////////////////
	// prefetch to memory, wishbone pipelined
	////////////////////////////////////////////////////////////////////////////

	logic                wb_cyc;
	logic                wb_stb;
	logic                wb_we;
	logic [FETCH_AW-1:0] wb_addr;
	logic                wb_stall;
	logic                wb_ack;
	logic                wb_err;
	logic [FETCH_DW-1:0] wb_rdata;

	fetch_decode u_decode
	(
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_pf_valid    (pf_valid),
		.i_pf_illegal  (pf_illegal),
		.i_pf_insn     (pf_insn),
		.i_pf_pc       (pf_pc),
		.i_ready       (i_ready),
		.i_jump        (i_jump),
		.i_flush       (i_flush),
		.i_jump_pc     (i_jump_pc),
		.o_pf_ready    (fetch_ready),
		.o_new_pc      (fetch_new_pc),
		.o_clear       (fetch_clear),
		.o_new_pc_addr (fetch_pc),
		.o_valid       (o_valid),
		.o_bus_err     (o_bus_err),
		.o_illegal_op  (o_illegal_op),
		.o_pc          (o_pc),
		.o_insn        (o_insn),
		.o_op          (o_op)
	);

	fetch_prefetch u_prefetch
	(
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_new_pc   (fetch_new_pc),
		.i_clear    (fetch_clear),
		.i_ready    (fetch_ready),
		.i_pc       (fetch_pc),
		.i_wb_stall (wb_stall),
		.i_wb_ack   (wb_ack),
		.i_wb_err   (wb_err),
		.i_wb_data  (wb_rdata),
		.o_valid    (pf_valid),
		.o_illegal  (pf_illegal),
		.o_insn     (pf_insn),
		.o_pc       (pf_pc),
		.o_wb_cyc   (wb_cyc),
		.o_wb_stb   (wb_stb),
		.o_wb_we    (wb_we),
		.o_wb_addr  (wb_addr)
	);

	fetch_imem u_imem
	(
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_we    (wb_we),
		.i_wb_addr  (wb_addr),
		.o_wb_stall (wb_stall),
		.o_wb_ack   (wb_ack),
		.o_wb_err   (wb_err),
		.o_wb_data  (wb_rdata)
	);

endmodule

//--- fetch_decode.sv
// one-entry decode register that classifies opcodes and steers the fetcher on branches, jumps and flushes

`timescale 1ns/1ps

module fetch_decode
(
	input  logic                          i_clk,
	input  logic                          i_arst_n,
	// word from the prefetch
	input  logic                          i_pf_valid,
	input  logic                          i_pf_illegal,
	input  logic [fetch_pkg::FETCH_DW-1:0] i_pf_insn,
	input  logic [fetch_pkg::FETCH_AW-1:0] i_pf_pc,
	// downstream handshake and control
	input  logic                          i_ready,
	input  logic                          i_jump,
	input  logic                          i_flush,
	input  logic [fetch_pkg::FETCH_AW-1:0] i_jump_pc,
	// steering of the prefetch
	output logic                          o_pf_ready,
	output logic                          o_new_pc,
	output logic                          o_clear,
	output logic [fetch_pkg::FETCH_AW-1:0] o_new_pc_addr,
	// decoded output
	output logic                          o_valid,
	output logic                          o_bus_err,
	output logic                          o_illegal_op,
	output logic [fetch_pkg::FETCH_AW-1:0] o_pc,
	output logic [fetch_pkg::FETCH_DW-1:0] o_insn,
	output fetch_pkg::fetch_op_e          o_op
);

	import fetch_pkg::*;

	fetch_op_e dec_op;
	logic      dec_undef;
	logic      accept;
	logic      take_branch;

	// classify the top nibble, anything unknown becomes OP_UNDEF
	always_comb
	begin
		case (i_pf_insn[31:28])
			OP_NOP:    dec_op = OP_NOP;
			OP_ALU:    dec_op = OP_ALU;
			OP_LOAD:   dec_op = OP_LOAD;
			OP_BRANCH: dec_op = OP_BRANCH;
			default:   dec_op = OP_UNDEF;
		endcase
	end

	assign dec_undef = (dec_op == OP_UNDEF);

	// a jump or flush throws away whatever would arrive, so nothing is taken
	// while one is active and the prefetch keeps its word
	assign o_pf_ready = !i_jump && !i_flush && (!o_valid || i_ready);
	assign accept     = i_pf_valid && o_pf_ready;

	// a word from a failed bus read is never treated as a branch
	assign take_branch = accept && !i_pf_illegal && (dec_op == OP_BRANCH);

	////////////////////////////////////////////////////////////////////////////
	// redirect towards the prefetch, jump wins over a branch
	////////////////////////////////////////////////////////////////////////////

	assign o_new_pc      = i_jump || take_branch;
	assign o_new_pc_addr = i_jump ? i_jump_pc : FETCH_AW'(i_pf_insn[23:0]);
	assign o_clear       = i_flush;

	////////////////////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_valid <= 1'b0;
		else if (i_jump || i_flush)
			o_valid <= 1'b0;
		else if (accept)
			o_valid <= 1'b1;
		else if (i_ready)
			o_valid <= 1'b0;
	end

	// payload only moves with a transfer, so it holds under back-pressure
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			o_pc         <= i_pf_pc;
			o_insn       <= i_pf_insn;
			o_op         <= dec_op;
			o_bus_err    <= i_pf_illegal;
			o_illegal_op <= dec_undef;
		end
	end

	// a stalled output item must survive until the consumer takes it
	a_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_valid && !i_ready && !i_jump && !i_flush
		|=> o_valid && $stable(o_pc) && $stable(o_insn) && $stable(o_op))
		else $error("decode: output changed while stalled");

endmodule

//--- fetch_prefetch.sv
// single-outstanding wishbone instruction fetcher that walks addresses and squashes stale results

`timescale 1ns/1ps

module fetch_prefetch
(
	input  logic                          i_clk,
	input  logic                          i_arst_n,
	// redirect and handshake from the decode stage
	input  logic                          i_new_pc,
	input  logic                          i_clear,
	input  logic                          i_ready,
	input  logic [fetch_pkg::FETCH_AW-1:0] i_pc,
	// wishbone pipelined responses
	input  logic                          i_wb_stall,
	input  logic                          i_wb_ack,
	input  logic                          i_wb_err,
	input  logic [fetch_pkg::FETCH_DW-1:0] i_wb_data,
	// fetched word towards the decode stage
	output logic                          o_valid,
	output logic                          o_illegal,
	output logic [fetch_pkg::FETCH_DW-1:0] o_insn,
	output logic [fetch_pkg::FETCH_AW-1:0] o_pc,
	// wishbone pipelined master
	output logic                          o_wb_cyc,
	output logic                          o_wb_stb,
	output logic                          o_wb_we,
	output logic [fetch_pkg::FETCH_AW-1:0] o_wb_addr
);

	import fetch_pkg::*;

	// set when a redirect lands while a bus cycle is still open
	logic                invalid;
	// address of the next word to fetch once the current one is handed over
	logic [FETCH_AW-1:0] req_addr;
	logic                resp_end;
	logic                start_fetch;

	// an instruction fetcher never writes
	assign o_wb_we = 1'b0;

	// the word on the output always belongs to the last bus address
	assign o_pc = o_wb_addr;

	// ack or err closes the single outstanding request
	assign resp_end = o_wb_cyc && (i_wb_ack || i_wb_err);

	// a new cycle starts on a redirect, after a squashed response, or when
	// the output register is free or being taken this cycle
	// a bus error blocks further fetches until new_pc or clear
	assign start_fetch = !o_wb_cyc
		&& (i_new_pc || invalid || (!o_illegal && (!o_valid || i_ready)));

	////////////////////////////////////////////////////////////////////////////
	// wishbone cycle and strobe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else if (resp_end)
		begin
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else if (start_fetch)
		begin
			o_wb_cyc <= 1'b1;
			o_wb_stb <= 1'b1;
		end
		else if (o_wb_cyc && !i_wb_stall)
		begin
			// request taken by the slave, keep cyc until the response
			o_wb_stb <= 1'b0;
		end
	end

	// remember a redirect that arrived mid-cycle so the response is dropped
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			invalid <= 1'b0;
		else if (!o_wb_cyc)
			invalid <= 1'b0;
		else if (i_new_pc || i_clear)
			invalid <= 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// address tracking
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			req_addr <= FETCH_RESET_PC;
		else if (i_new_pc)
			req_addr <= i_pc;
		else if (i_clear && o_valid)
			// the held word is thrown away, so it must be fetched again
			req_addr <= o_wb_addr;
		else if (resp_end && i_wb_ack && !i_wb_err && !invalid && !i_clear)
			req_addr <= req_addr + 1'b1;
	end

	// the bus address only moves between cycles, and not while the output
	// word still waits for the decode stage
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_wb_addr <= FETCH_RESET_PC;
		else if (!o_wb_cyc)
		begin
			if (i_new_pc)
				o_wb_addr <= i_pc;
			else if (i_ready || !o_valid)
				o_wb_addr <= req_addr;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// output word and flags
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (resp_end && i_wb_ack)
			o_insn <= i_wb_data;
	end

	// o_illegal stays set after the word is taken, which is what holds off
	// the next fetch after a bus error
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_valid   <= 1'b0;
			o_illegal <= 1'b0;
		end
		else if (i_new_pc || i_clear)
		begin
			o_valid   <= 1'b0;
			o_illegal <= 1'b0;
		end
		else if (resp_end)
		begin
			o_valid   <= !invalid;
			o_illegal <= i_wb_err && !invalid;
		end
		else if (i_ready)
			o_valid <= 1'b0;
	end

	// address may not move inside a bus cycle
	a_addr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_wb_cyc |=> !o_wb_cyc || $stable(o_wb_addr))
		else $error("prefetch: wb address changed during an open cycle");

	// a new fetch only starts once the held word has been handed over
	a_valid_excl_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_valid && o_wb_cyc))
		else $error("prefetch: output valid during an open bus cycle");

endmodule

//--- fetch_imem.sv
// read-only wishbone pipelined instruction memory with a fixed wait and out-of-range errors

`timescale 1ns/1ps

module fetch_imem
(
	input  logic                          i_clk,
	input  logic                          i_arst_n,
	input  logic                          i_wb_cyc,
	input  logic                          i_wb_stb,
	input  logic                          i_wb_we,
	input  logic [fetch_pkg::FETCH_AW-1:0] i_wb_addr,
	output logic                          o_wb_stall,
	output logic                          o_wb_ack,
	output logic                          o_wb_err,
	output logic [fetch_pkg::FETCH_DW-1:0] o_wb_data
);

	import fetch_pkg::*;

	logic [FETCH_DW-1:0] mem [IMEM_DEPTH];
	logic                accept;
	logic                in_range;
	logic [IMEM_CW-1:0]  wait_cnt;
	// good read pending, otherwise the pending response is an err
	logic                resp_ok;

	// image is shared with the testbench reference model
	initial
	begin
		$readmemh("program.hex", mem);
	end

	assign accept   = i_wb_cyc && i_wb_stb && !o_wb_stall;
	assign in_range = (i_wb_addr < FETCH_AW'(IMEM_DEPTH));

	// busy from the accepted strobe up to and including the response cycle
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			wait_cnt <= '0;
			resp_ok  <= 1'b0;
		end
		else if (!i_wb_cyc)
			// master dropped the cycle, abandon any pending answer
			wait_cnt <= '0;
		else if (accept)
		begin
			wait_cnt <= IMEM_CW'(IMEM_WAIT);
			resp_ok  <= in_range && !i_wb_we;
		end
		else if (wait_cnt != '0)
			wait_cnt <= wait_cnt - 1'b1;
	end

	// the read happens on acceptance, the index wraps for bad addresses
	// but then the data is never acked
	always_ff @(posedge i_clk)
	begin
		if (accept)
			o_wb_data <= mem[i_wb_addr[IMEM_AW-1:0]];
	end

	assign o_wb_stall = (wait_cnt != '0);
	assign o_wb_ack   = (wait_cnt == IMEM_CW'(1)) && resp_ok;
	assign o_wb_err   = (wait_cnt == IMEM_CW'(1)) && !resp_ok;

endmodule

//--- fetch_pkg.sv
// fetch package with bus widths, instruction memory geometry, reset pc and opcodes

package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus and datapath widths
	////////////////////////////////////////////////////////////////////////////

	// word address width of the instruction bus, byte offset bits are dropped
	localparam int FETCH_AW = 30;

	// width of one instruction and of the bus data path
	localparam int FETCH_DW = 32;

	// first word address fetched once reset is released
	localparam logic [FETCH_AW-1:0] FETCH_RESET_PC = '0;

	////////////////////////////////////////////////////////////////////////////
	// instruction memory
	////////////////////////////////////////////////////////////////////////////

	// number of words in the instruction memory, higher addresses answer err
	localparam int IMEM_DEPTH = 64;

	// index width needed to address one of the IMEM_DEPTH words
	localparam int IMEM_AW = $clog2(IMEM_DEPTH);

	// cycles from the accepted strobe to the ack or err
	localparam int IMEM_WAIT = 1;

	// width of the wait counter inside the memory
	localparam int IMEM_CW = $clog2(IMEM_WAIT + 1);

	////////////////////////////////////////////////////////////////////////////
	// opcodes
	////////////////////////////////////////////////////////////////////////////

	// the opcode sits in instruction bits 31 to 28
	// any code not listed here is reported as OP_UNDEF
	typedef enum logic [3:0]
	{
		OP_NOP    = 4'h0,
		OP_ALU    = 4'h1,
		OP_LOAD   = 4'h2,
		OP_BRANCH = 4'h3,
		OP_UNDEF  = 4'hf
	} fetch_op_e;

endpackage
